// ==== executeStage.f ====
execPkg.sv
alu32Bit.sv
executeUnit.sv
idExRegister.sv
exMemRegister.sv
executeStage.sv
tbExecuteStage.sv

// ==== Bender.yml ====
package:
  name: executestage

sources:
  - execPkg.sv
  - alu32Bit.sv
  - executeUnit.sv
  - idExRegister.sv
  - exMemRegister.sv
  - executeStage.sv
  - target: test
    files:
      - tbExecuteStage.sv

// ==== tbExecuteStage.sv ====
`timescale 1ns/1ps

module tbExecuteStage import execPkg::*; ();

    localparam int numCycles = 2000;
    localparam int drainLimit = 10;

    // One EX/MEM output set, controls as {branch, memRead, memWrite, regWrite, memToReg}
    typedef struct packed {
        logic                    valid;
        logic [4:0]              ctrl;
        logic [resultWidth-1:0]  alu;
        logic                    zero;
        logic [dataWidth-1:0]    target;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0]    writeData;
    } stageRecord;

    // Widest value the check has to compare, a whole record
    localparam int recordWidth = $bits(stageRecord);

    logic Clk = 1'b0;
    logic arstN;
    logic stall;
    logic flush;
    logic validIn;
    logic branchIn;
    logic memReadIn;
    logic memWriteIn;
    logic regWriteIn;
    logic memToRegIn;
    logic regDstIn;
    logic aluSrcIn;
    logic altAluSrc1In;
    logic zeroAluSrc1In;
    logic [aluOpWidth-1:0] aluOpIn;
    logic [dataWidth-1:0] pcValueIn;
    logic [dataWidth-1:0] readData1In;
    logic [dataWidth-1:0] readData2In;
    logic [dataWidth-1:0] signExtendOffsetIn;
    logic [regAddrWidth-1:0] rdFieldIn;
    logic [regAddrWidth-1:0] rtFieldIn;
    logic validOut;
    logic branchOut;
    logic memReadOut;
    logic memWriteOut;
    logic regWriteOut;
    logic memToRegOut;
    logic [dataWidth-1:0] branchTargetAddressOut;
    logic [resultWidth-1:0] aluOut;
    logic zeroOut;
    logic [regAddrWidth-1:0] destinationRegOut;
    logic [dataWidth-1:0] memoryWriteDataOut;

    // Front entry mirrors what sits in ID/EX
    stageRecord expectedQ[$];
    int pushedValid;
    int observedValid;

    always #4 Clk = ~Clk;

    executeStage u_executeStage (.*);

    //////////////////////////////////////////////////
    // Failure reporting and the check
    //////////////////////////////////////////////////

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkValue(input string what,
                              input logic [recordWidth-1:0] actual,
                              input logic [recordWidth-1:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            abortRun();
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [resultWidth-1:0] aluModel(input logic [aluOpWidth-1:0] op,
                                                        input logic [dataWidth-1:0] a,
                                                        input logic [dataWidth-1:0] b);
        logic [4:0]  sh;
        logic [31:0] low;
        logic [63:0] wideA;
        logic [63:0] wideB;
        logic [63:0] res;
        sh = a[4:0];
        low = '0;
        res = '0;
        case (op)
            opAdd: low = a + b;
            opSub: low = a - b;
            opAnd: low = a & b;
            opOr: low = a | b;
            opXor: low = a ^ b;
            opNor: low = ~(a | b);
            // Differing signs decide by sign bit alone
            opSlt: low = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, (a < b)};
            opSltu: low = {31'b0, (a < b)};
            opSll: low = b << sh;
            opSrl: low = b >> sh;
            // Logical shift, then refill vacated bits with the sign
            opSra: low = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            default: low = '0;
        endcase
        res = {32'h0, low};
        if (op == opMult) begin
            wideA = {{32{a[31]}}, a};
            wideB = {{32{b[31]}}, b};
            res = wideA * wideB;
        end else if (op == opMultu) begin
            wideA = {32'h0, a};
            wideB = {32'h0, b};
            res = wideA * wideB;
        end
        return res;
    endfunction

    // Expected record for the inputs now on the pins
    function automatic stageRecord modelRecord();
        stageRecord r;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        if (zeroAluSrc1In) begin
            a = '0;
        end else begin
            a = altAluSrc1In ? readData2In : readData1In;
        end
        b = aluSrcIn ? signExtendOffsetIn : readData2In;
        r.valid = validIn && !flush;
        r.ctrl = r.valid ? {branchIn, memReadIn, memWriteIn, regWriteIn, memToRegIn} : 5'b0;
        r.alu = aluModel(aluOpIn, a, b);
        r.zero = (r.alu == 64'h0);
        // Offset times four, wraps at 32 bits
        r.target = pcValueIn + {signExtendOffsetIn[29:0], 2'b00};
        r.dest = regDstIn ? rdFieldIn : rtFieldIn;
        r.writeData = readData2In;
        return r;
    endfunction

    function automatic stageRecord sampleOutputs();
        stageRecord r;
        r.valid = validOut;
        r.ctrl = {branchOut, memReadOut, memWriteOut, regWriteOut, memToRegOut};
        r.alu = aluOut;
        r.zero = zeroOut;
        r.target = branchTargetAddressOut;
        r.dest = destinationRegOut;
        r.writeData = memoryWriteDataOut;
        return r;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Corner values mixed with plain random words
    function automatic logic [dataWidth-1:0] randomWord();
        case ($urandom_range(7))
            0: return 32'h0;
            1: return 32'hffff_ffff;
            2: return 32'h8000_0000;
            3: return $urandom_range(31);
            default: return $urandom;
        endcase
    endfunction

    task automatic driveRandomInputs();
        logic memRd;
        memRd = $urandom_range(1);
        stall = ($urandom_range(4) == 0);
        flush = ($urandom_range(7) == 0);
        validIn = ($urandom_range(7) != 0);
        branchIn = $urandom_range(1);
        // Load and store never together
        memReadIn = memRd;
        memWriteIn = !memRd && ($urandom_range(1) == 1);
        regWriteIn = $urandom_range(1);
        memToRegIn = $urandom_range(1);
        regDstIn = $urandom_range(1);
        aluSrcIn = $urandom_range(1);
        altAluSrc1In = $urandom_range(1);
        zeroAluSrc1In = $urandom_range(1);
        aluOpIn = $urandom_range(12);
        readData1In = randomWord();
        // Equal operands now and then for compares and zero results
        readData2In = ($urandom_range(7) == 0) ? readData1In : randomWord();
        pcValueIn = $urandom;
        signExtendOffsetIn = randomWord();
        rdFieldIn = $urandom_range(31);
        rtFieldIn = $urandom_range(31);
    endtask

    // Drive at the falling edge, check at the next one
    task automatic runCycle(input bit idle);
        stageRecord held;
        stageRecord act;
        stageRecord exp;
        bit advanced;
        held = sampleOutputs();
        if (idle) begin
            stall = 1'b0;
            flush = 1'b0;
            validIn = 1'b0;
        end else begin
            driveRandomInputs();
        end
        advanced = !stall;
        if (advanced) begin
            exp = modelRecord();
            expectedQ.push_back(exp);
            if (exp.valid) begin
                pushedValid++;
            end
        end
        @(negedge Clk);
        act = sampleOutputs();
        if (advanced) begin
            exp = expectedQ.pop_front();
            checkValue("validOut", act.valid, exp.valid);
            checkValue("control outputs", act.ctrl, exp.ctrl);
            // Data of a bubble is don't-care
            if (exp.valid) begin
                checkValue("aluOut", act.alu, exp.alu);
                checkValue("zeroOut", act.zero, exp.zero);
                checkValue("branchTargetAddressOut", act.target, exp.target);
                checkValue("destinationRegOut", act.dest, exp.dest);
                checkValue("memoryWriteDataOut", act.writeData, exp.writeData);
                observedValid++;
            end
        end else begin
            // Stalled, every output must hold
            checkValue("outputs under stall", act, held);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        stageRecord bubble;
        int drainCycles;
        void'($urandom(32'h9bc6_9ab1));
        arstN = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        validIn = 1'b0;
        branchIn = 1'b0;
        memReadIn = 1'b0;
        memWriteIn = 1'b0;
        regWriteIn = 1'b0;
        memToRegIn = 1'b0;
        regDstIn = 1'b0;
        aluSrcIn = 1'b0;
        altAluSrc1In = 1'b0;
        zeroAluSrc1In = 1'b0;
        aluOpIn = '0;
        pcValueIn = '0;
        readData1In = '0;
        readData2In = '0;
        signExtendOffsetIn = '0;
        rdFieldIn = '0;
        rtFieldIn = '0;
        pushedValid = 0;
        observedValid = 0;

        repeat (3) @(posedge Clk);
        @(negedge Clk);
        arstN = 1'b1;

        // Reset state, nothing valid yet
        checkValue("outputs after reset", sampleOutputs(), '0);

        // ID/EX starts as a bubble
        bubble = '0;
        expectedQ.push_back(bubble);

        for (int i = 0; i < numCycles; i++) begin
            runCycle(1'b0);
        end

        // Flush the pipe until every instruction came out
        drainCycles = 0;
        while (observedValid != pushedValid) begin
            if (drainCycles == drainLimit) begin
                $display("Timeout: %0d of %0d instructions never reached the outputs",
                         pushedValid - observedValid, pushedValid);
                abortRun();
            end
            runCycle(1'b1);
            drainCycles++;
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ps

module executeStage import execPkg::*; (
    input  logic                    Clk,
    input  logic                    arstN,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    validIn,
    input  logic                    branchIn,
    input  logic                    memReadIn,
    input  logic                    memWriteIn,
    input  logic                    regWriteIn,
    input  logic                    memToRegIn,
    input  logic                    regDstIn,
    input  logic                    aluSrcIn,
    input  logic                    altAluSrc1In,
    input  logic                    zeroAluSrc1In,
    input  logic [aluOpWidth-1:0]   aluOpIn,
    input  logic [dataWidth-1:0]    pcValueIn,
    input  logic [dataWidth-1:0]    readData1In,
    input  logic [dataWidth-1:0]    readData2In,
    input  logic [dataWidth-1:0]    signExtendOffsetIn,
    input  logic [regAddrWidth-1:0] rdFieldIn,
    input  logic [regAddrWidth-1:0] rtFieldIn,
    output logic                    validOut,
    output logic                    branchOut,
    output logic                    memReadOut,
    output logic                    memWriteOut,
    output logic                    regWriteOut,
    output logic                    memToRegOut,
    output logic [dataWidth-1:0]    branchTargetAddressOut,
    output logic [resultWidth-1:0]  aluOut,
    output logic                    zeroOut,
    output logic [regAddrWidth-1:0] destinationRegOut,
    output logic [dataWidth-1:0]    memoryWriteDataOut
);

    //////////////////////////////////////////////////
    // ID/EX outputs
    //////////////////////////////////////////////////

    logic                    exValid;
    // Controls bypassing the execute unit
    logic                    exBranch;
    logic                    exMemRead;
    logic                    exMemWrite;
    logic                    exRegWrite;
    logic                    exMemToReg;
    // Controls consumed in execute
    logic                    exRegDst;
    logic                    exAluSrc;
    logic                    exAltAluSrc1;
    logic                    exZeroAluSrc1;
    logic [aluOpWidth-1:0]   exAluOp;
    logic [dataWidth-1:0]    exPcValue;
    logic [dataWidth-1:0]    exReadData1;
    logic [dataWidth-1:0]    exReadData2;
    logic [dataWidth-1:0]    exSignExtendOffset;
    logic [regAddrWidth-1:0] exRdField;
    logic [regAddrWidth-1:0] exRtField;

    // Execute unit results
    logic [resultWidth-1:0]  exAluResult;
    logic                    exZero;
    logic [dataWidth-1:0]    exBranchTarget;
    logic [regAddrWidth-1:0] exDestinationReg;
    logic [dataWidth-1:0]    exMemoryWriteData;

    idExRegister u_idExRegister (
        .Clk                 (Clk),
        .arstN               (arstN),
        .stall               (stall),
        .flush               (flush),
        .validIn             (validIn),
        .branchIn            (branchIn),
        .memReadIn           (memReadIn),
        .memWriteIn          (memWriteIn),
        .regWriteIn          (regWriteIn),
        .memToRegIn          (memToRegIn),
        .regDstIn            (regDstIn),
        .aluSrcIn            (aluSrcIn),
        .altAluSrc1In        (altAluSrc1In),
        .zeroAluSrc1In       (zeroAluSrc1In),
        .aluOpIn             (aluOpIn),
        .pcValueIn           (pcValueIn),
        .readData1In         (readData1In),
        .readData2In         (readData2In),
        .signExtendOffsetIn  (signExtendOffsetIn),
        .rdFieldIn           (rdFieldIn),
        .rtFieldIn           (rtFieldIn),
        .validOut            (exValid),
        .branchOut           (exBranch),
        .memReadOut          (exMemRead),
        .memWriteOut         (exMemWrite),
        .regWriteOut         (exRegWrite),
        .memToRegOut         (exMemToReg),
        .regDstOut           (exRegDst),
        .aluSrcOut           (exAluSrc),
        .altAluSrc1Out       (exAltAluSrc1),
        .zeroAluSrc1Out      (exZeroAluSrc1),
        .aluOpOut            (exAluOp),
        .pcValueOut          (exPcValue),
        .readData1Out        (exReadData1),
        .readData2Out        (exReadData2),
        .signExtendOffsetOut (exSignExtendOffset),
        .rdFieldOut          (exRdField),
        .rtFieldOut          (exRtField)
    );

    // Combinational, same cycle as ID/EX output
    executeUnit u_executeUnit (
        .aluSrc              (exAluSrc),
        .altAluSrc1          (exAltAluSrc1),
        .zeroAluSrc1         (exZeroAluSrc1),
        .regDst              (exRegDst),
        .aluOp               (exAluOp),
        .pcValue             (exPcValue),
        .readData1           (exReadData1),
        .readData2           (exReadData2),
        .signExtendOffset    (exSignExtendOffset),
        .rdField             (exRdField),
        .rtField             (exRtField),
        .aluOut              (exAluResult),
        .zero                (exZero),
        .branchTargetAddress (exBranchTarget),
        .destinationReg      (exDestinationReg),
        .memoryWriteData     (exMemoryWriteData)
    );

    exMemRegister u_exMemRegister (
        .Clk                    (Clk),
        .arstN                  (arstN),
        .stall                  (stall),
        .validIn                (exValid),
        .branchIn               (exBranch),
        .memReadIn              (exMemRead),
        .memWriteIn             (exMemWrite),
        .regWriteIn             (exRegWrite),
        .memToRegIn             (exMemToReg),
        .aluOutIn               (exAluResult),
        .zeroIn                 (exZero),
        .branchTargetAddressIn  (exBranchTarget),
        .destinationRegIn       (exDestinationReg),
        .memoryWriteDataIn      (exMemoryWriteData),
        .validOut               (validOut),
        .branchOut              (branchOut),
        .memReadOut             (memReadOut),
        .memWriteOut            (memWriteOut),
        .regWriteOut            (regWriteOut),
        .memToRegOut            (memToRegOut),
        .branchTargetAddressOut (branchTargetAddressOut),
        .aluOut                 (aluOut),
        .zeroOut                (zeroOut),
        .destinationRegOut      (destinationRegOut),
        .memoryWriteDataOut     (memoryWriteDataOut)
    );

endmodule

// ==== exMemRegister.sv ====
`timescale 1ns/1ps

module exMemRegister import execPkg::*; (
    input  logic                    Clk,
    input  logic                    arstN,
    input  logic                    stall,
    input  logic                    validIn,
    // Controls straight from ID/EX
    input  logic                    branchIn,
    input  logic                    memReadIn,
    input  logic                    memWriteIn,
    input  logic                    regWriteIn,
    input  logic                    memToRegIn,
    // Execute results
    input  logic [resultWidth-1:0]  aluOutIn,
    input  logic                    zeroIn,
    input  logic [dataWidth-1:0]    branchTargetAddressIn,
    input  logic [regAddrWidth-1:0] destinationRegIn,
    input  logic [dataWidth-1:0]    memoryWriteDataIn,
    // Toward the memory stage
    output logic                    validOut,
    output logic                    branchOut,
    output logic                    memReadOut,
    output logic                    memWriteOut,
    output logic                    regWriteOut,
    output logic                    memToRegOut,
    output logic [dataWidth-1:0]    branchTargetAddressOut,
    output logic [resultWidth-1:0]  aluOut,
    output logic                    zeroOut,
    output logic [regAddrWidth-1:0] destinationRegOut,
    output logic [dataWidth-1:0]    memoryWriteDataOut
);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            validOut <= 1'b0;
            branchOut <= 1'b0;
            memReadOut <= 1'b0;
            memWriteOut <= 1'b0;
            regWriteOut <= 1'b0;
            memToRegOut <= 1'b0;
            branchTargetAddressOut <= '0;
            aluOut <= '0;
            zeroOut <= 1'b0;
            destinationRegOut <= '0;
            memoryWriteDataOut <= '0;
        end else if (!stall) begin
            validOut <= validIn;
            // Bubble must not touch memory or registers
            branchOut <= branchIn && validIn;
            memReadOut <= memReadIn && validIn;
            memWriteOut <= memWriteIn && validIn;
            regWriteOut <= regWriteIn && validIn;
            memToRegOut <= memToRegIn && validIn;
            // Data loads regardless, harmless on a bubble
            branchTargetAddressOut <= branchTargetAddressIn;
            aluOut <= aluOutIn;
            zeroOut <= zeroIn;
            destinationRegOut <= destinationRegIn;
            memoryWriteDataOut <= memoryWriteDataIn;
        end
    end

    // Memory stage sees a quiet bubble, also across stalls
    bubbleQuiet: assert property (
        @(posedge Clk) disable iff (!arstN)
        !validOut |-> !(branchOut || memReadOut || memWriteOut ||
                        regWriteOut || memToRegOut)
    );

endmodule

// ==== idExRegister.sv ====
`timescale 1ns/1ps

module idExRegister import execPkg::*; (
    input  logic                    Clk,
    input  logic                    arstN,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    validIn,
    // Controls forwarded to later stages
    input  logic                    branchIn,
    input  logic                    memReadIn,
    input  logic                    memWriteIn,
    input  logic                    regWriteIn,
    input  logic                    memToRegIn,
    // Controls used in execute
    input  logic                    regDstIn,
    input  logic                    aluSrcIn,
    input  logic                    altAluSrc1In,
    input  logic                    zeroAluSrc1In,
    input  logic [aluOpWidth-1:0]   aluOpIn,
    // Operands and fields
    input  logic [dataWidth-1:0]    pcValueIn,
    input  logic [dataWidth-1:0]    readData1In,
    input  logic [dataWidth-1:0]    readData2In,
    input  logic [dataWidth-1:0]    signExtendOffsetIn,
    input  logic [regAddrWidth-1:0] rdFieldIn,
    input  logic [regAddrWidth-1:0] rtFieldIn,
    output logic                    validOut,
    output logic                    branchOut,
    output logic                    memReadOut,
    output logic                    memWriteOut,
    output logic                    regWriteOut,
    output logic                    memToRegOut,
    output logic                    regDstOut,
    output logic                    aluSrcOut,
    output logic                    altAluSrc1Out,
    output logic                    zeroAluSrc1Out,
    output logic [aluOpWidth-1:0]   aluOpOut,
    output logic [dataWidth-1:0]    pcValueOut,
    output logic [dataWidth-1:0]    readData1Out,
    output logic [dataWidth-1:0]    readData2Out,
    output logic [dataWidth-1:0]    signExtendOffsetOut,
    output logic [regAddrWidth-1:0] rdFieldOut,
    output logic [regAddrWidth-1:0] rtFieldOut
);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            validOut <= 1'b0;
            branchOut <= 1'b0;
            memReadOut <= 1'b0;
            memWriteOut <= 1'b0;
            regWriteOut <= 1'b0;
            memToRegOut <= 1'b0;
            regDstOut <= 1'b0;
            aluSrcOut <= 1'b0;
            altAluSrc1Out <= 1'b0;
            zeroAluSrc1Out <= 1'b0;
            aluOpOut <= '0;
            pcValueOut <= '0;
            readData1Out <= '0;
            readData2Out <= '0;
            signExtendOffsetOut <= '0;
            rdFieldOut <= '0;
            rtFieldOut <= '0;
        end else if (!stall) begin
            // Flush turns this slot into a bubble
            validOut <= validIn && !flush;
            branchOut <= branchIn;
            memReadOut <= memReadIn;
            memWriteOut <= memWriteIn;
            regWriteOut <= regWriteIn;
            memToRegOut <= memToRegIn;
            regDstOut <= regDstIn;
            aluSrcOut <= aluSrcIn;
            altAluSrc1Out <= altAluSrc1In;
            zeroAluSrc1Out <= zeroAluSrc1In;
            aluOpOut <= aluOpIn;
            pcValueOut <= pcValueIn;
            readData1Out <= readData1In;
            readData2Out <= readData2In;
            signExtendOffsetOut <= signExtendOffsetIn;
            rdFieldOut <= rdFieldIn;
            rtFieldOut <= rtFieldIn;
        end
        // Stall keeps everything as is
    end

    // Decode never issues a load and a store together
    memAccessExclusive: assert property (
        @(posedge Clk) disable iff (!arstN)
        validOut |-> !(memReadOut && memWriteOut)
    );

endmodule

// ==== executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit import execPkg::*; (
    // Operand and destination selects
    input  logic                    aluSrc,
    input  logic                    altAluSrc1,
    input  logic                    zeroAluSrc1,
    input  logic                    regDst,
    input  logic [aluOpWidth-1:0]   aluOp,
    // Data from ID/EX
    input  logic [dataWidth-1:0]    pcValue,
    input  logic [dataWidth-1:0]    readData1,
    input  logic [dataWidth-1:0]    readData2,
    input  logic [dataWidth-1:0]    signExtendOffset,
    input  logic [regAddrWidth-1:0] rdField,
    input  logic [regAddrWidth-1:0] rtField,
    // Results toward EX/MEM
    output logic [resultWidth-1:0]  aluOut,
    output logic                    zero,
    output logic [dataWidth-1:0]    branchTargetAddress,
    output logic [regAddrWidth-1:0] destinationReg,
    output logic [dataWidth-1:0]    memoryWriteData
);

    // First ALU input
    logic [dataWidth-1:0] operandA;
    // Second ALU input
    logic [dataWidth-1:0] operandB;

    //////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////

    // Zero source wins over the alternate source
    always_comb begin
        if (zeroAluSrc1) begin
            operandA = '0;
        end else if (altAluSrc1) begin
            // Shifts take rt here
            operandA = readData2;
        end else begin
            operandA = readData1;
        end
    end

    // Immediate or register
    assign operandB = aluSrc ? signExtendOffset : readData2;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    alu32Bit u_alu32Bit (
        .aluOp    (aluOp),
        .operandA (operandA),
        .operandB (operandB),
        .result   (aluOut),
        .zero     (zero)
    );

    //////////////////////////////////////////////////
    // Side paths
    //////////////////////////////////////////////////

    // R-type writes rd, I-type writes rt
    assign destinationReg = regDst ? rdField : rtField;

    // Word offset to byte offset, wraps at 32 bits
    assign branchTargetAddress = pcValue + (signExtendOffset << 2);

    // Store data is always rt
    assign memoryWriteData = readData2;

endmodule

// ==== alu32Bit.sv ====
`timescale 1ns/1ps

module alu32Bit import execPkg::*; (
    input  logic [aluOpWidth-1:0]  aluOp,
    input  logic [dataWidth-1:0]   operandA,
    input  logic [dataWidth-1:0]   operandB,
    output logic [resultWidth-1:0] result,
    output logic                   zero
);

    // Low five bits of operand A
    logic [shiftAmtWidth-1:0] shiftAmt;
    // Narrow result, zero-extended later
    logic [dataWidth-1:0]     narrowResult;
    // Set when the op produces a full-width product
    logic                     isProduct;
    // Both products, 64-bit context
    logic signed [resultWidth-1:0] productSigned;
    logic [resultWidth-1:0]        productUnsigned;

    assign shiftAmt = operandA[shiftAmtWidth-1:0];

    // Operands sign-extended before the multiply
    assign productSigned = $signed(operandA) * $signed(operandB);
    // Operands zero-extended before the multiply
    assign productUnsigned = operandA * operandB;

    //////////////////////////////////////////////////
    // Operation decode
    //////////////////////////////////////////////////

    always_comb begin
        narrowResult = '0;
        isProduct = 1'b0;
        case (aluOp)
            opAdd: narrowResult = operandA + operandB;
            opSub: narrowResult = operandA - operandB;
            opAnd: narrowResult = operandA & operandB;
            opOr: narrowResult = operandA | operandB;
            opXor: narrowResult = operandA ^ operandB;
            opNor: narrowResult = ~(operandA | operandB);
            // Signed compare
            opSlt: begin
                narrowResult = {{(dataWidth-1){1'b0}},
                                ($signed(operandA) < $signed(operandB))};
            end
            // Unsigned compare
            opSltu: begin
                narrowResult = {{(dataWidth-1){1'b0}}, (operandA < operandB)};
            end
            // Shifts move operand B, amount from operand A
            opSll: narrowResult = operandB << shiftAmt;
            opSrl: narrowResult = operandB >> shiftAmt;
            // Arithmetic shift keeps the sign of B
            opSra: narrowResult = $signed(operandB) >>> shiftAmt;
            opMult: isProduct = 1'b1;
            opMultu: isProduct = 1'b1;
            // Reserved codes
            default: narrowResult = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Result and flag
    //////////////////////////////////////////////////

    always_comb begin
        if (isProduct) begin
            // Signed or unsigned product, picked by the op
            result = (aluOp == opMult) ? productSigned : productUnsigned;
        end else begin
            // Narrow ops fill the low word only
            result = {{(resultWidth-dataWidth){1'b0}}, narrowResult};
        end
    end

    // All 64 bits clear
    assign zero = (result == '0);

endmodule

// ==== execPkg.sv ====
package execPkg;

    //////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////

    // One operand word
    localparam int dataWidth = 32;
    // Full ALU result, wide enough for a product
    localparam int resultWidth = 64;
    // Register-field index
    localparam int regAddrWidth = 5;
    // Shift amount taken from operand A
    localparam int shiftAmtWidth = 5;
    // ALU operation code
    localparam int aluOpWidth = 4;

    //////////////////////////////////////////////////
    // ALU operation codes
    //////////////////////////////////////////////////

    // Arithmetic
    localparam logic [aluOpWidth-1:0] opAdd = 4'd0;
    localparam logic [aluOpWidth-1:0] opSub = 4'd1;
    // Bitwise logic
    localparam logic [aluOpWidth-1:0] opAnd = 4'd2;
    localparam logic [aluOpWidth-1:0] opOr = 4'd3;
    localparam logic [aluOpWidth-1:0] opXor = 4'd4;
    localparam logic [aluOpWidth-1:0] opNor = 4'd5;
    // Compare, result is 1 or 0
    localparam logic [aluOpWidth-1:0] opSlt = 4'd6;
    localparam logic [aluOpWidth-1:0] opSltu = 4'd7;
    // Shifts of operand B
    localparam logic [aluOpWidth-1:0] opSll = 4'd8;
    localparam logic [aluOpWidth-1:0] opSrl = 4'd9;
    localparam logic [aluOpWidth-1:0] opSra = 4'd10;
    // Full 64-bit products
    localparam logic [aluOpWidth-1:0] opMult = 4'd11;
    localparam logic [aluOpWidth-1:0] opMultu = 4'd12;
    // Codes 13 to 15 reserved, ALU returns zero

endpackage
